/* hdl/lsu_pkg.sv */
package lsu_pkg;

  // widths seen by the core and by the memory
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [7:0]  strb_t;

  // load funct3 codes, unknown codes behave as a word load
  typedef enum logic [2:0] {
    LD_BS = 3'd0,
    LD_HS = 3'd1,
    LD_W  = 3'd2,
    LD_BU = 3'd4,
    LD_HU = 3'd5
  } load_func_t;

  // store funct3 codes, unknown codes behave as a byte store
  typedef enum logic [2:0] {
    ST_B = 3'd0,
    ST_H = 3'd1,
    ST_W = 3'd2
  } store_func_t;

endpackage

/* hdl/lsu.sv */
`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rstn,

  // core load request and response
  input  addr_t       raddr,
  input  load_func_t  rfunc,
  input  logic        rreq_valid,
  output logic        rreq_ready,
  output word_t       rdata,
  output logic        rres_valid,
  input  logic        rres_ready,

  // core store request and response
  input  addr_t       waddr,
  input  store_func_t wfunc,
  input  word_t       wdata,
  input  logic        wreq_valid,
  output logic        wreq_ready,
  output logic        wres_valid,
  input  logic        wres_ready,

  // memory read channels
  output addr_t       mem_araddr,
  output logic        mem_arvalid,
  input  logic        mem_arready,
  input  beat_t       mem_rdata,
  input  logic        mem_rvalid,
  output logic        mem_rready,

  // memory write channels
  output addr_t       mem_awaddr,
  output logic        mem_awvalid,
  input  logic        mem_awready,
  output beat_t       mem_wdata,
  output strb_t       mem_wstrb,
  output logic        mem_wvalid,
  input  logic        mem_wready,
  input  logic        mem_bvalid,
  output logic        mem_bready
);

  logic [2:0] roff_q;
  load_func_t rfunc_q;
  beat_t      rbeat_shifted;
  word_t      rword;

  strb_t      wstrb_base;
  logic       addr_pending;
  logic       data_pending;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;

  // load path, straight through to the AR and R channels
  assign mem_arvalid = rreq_valid;
  assign mem_araddr  = raddr;
  assign rreq_ready  = mem_arready;
  assign rres_valid  = mem_rvalid;
  assign mem_rready  = rres_ready;

  // offset and function are needed when the beat comes back
  always_ff @(posedge clk) begin
    if (rreq_valid && rreq_ready) begin
      roff_q  <= raddr[2:0];
      rfunc_q <= rfunc;
    end
  end

  assign rbeat_shifted = mem_rdata >> {roff_q, 3'b000};

  always_comb begin
    case (rfunc_q)
      LD_BS:   rword = {{24{rbeat_shifted[7]}}, rbeat_shifted[7:0]};
      LD_BU:   rword = {24'b0, rbeat_shifted[7:0]};
      LD_HS:   rword = {{16{rbeat_shifted[15]}}, rbeat_shifted[15:0]};
      LD_HU:   rword = {16'b0, rbeat_shifted[15:0]};
      default: rword = rbeat_shifted[31:0];
    endcase
  end

  assign rdata = rword;

  // store lane placement
  always_comb begin
    case (wfunc)
      ST_H:    wstrb_base = 8'b0000_0011;
      ST_W:    wstrb_base = 8'b0000_1111;
      default: wstrb_base = 8'b0000_0001;
    endcase
  end

  assign mem_awaddr = waddr;
  assign mem_wdata  = beat_t'(wdata) << {waddr[2:0], 3'b000};
  assign mem_wstrb  = wstrb_base << waddr[2:0];

  assign aw_fire = mem_awvalid && mem_awready;
  assign w_fire  = mem_wvalid && mem_wready;
  assign b_fire  = mem_bvalid && mem_bready;

  // pending flags keep AW and W from being sent twice
  always_ff @(posedge clk) begin
    if (!rstn) begin
      addr_pending <= 1'b1;
      data_pending <= 1'b1;
    end else begin
      if (aw_fire) begin
        addr_pending <= 1'b0;
      end
      if (w_fire) begin
        data_pending <= 1'b0;
      end
      if (b_fire) begin
        addr_pending <= 1'b1;
        data_pending <= 1'b1;
      end
    end
  end

  assign mem_awvalid = wreq_valid && addr_pending;
  assign mem_wvalid  = wreq_valid && data_pending;

  // both flags clear means the request is waiting on B
  assign wreq_ready = (addr_pending || data_pending) &&
                      (mem_awready || !addr_pending) &&
                      (mem_wready || !data_pending);

  assign wres_valid = mem_bvalid;
  assign mem_bready = wres_ready;

endmodule

/* hdl/axi_sram.sv */
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  rstn,

  input  addr_t mem_araddr,
  input  logic  mem_arvalid,
  output logic  mem_arready,
  output beat_t mem_rdata,
  output logic  mem_rvalid,
  input  logic  mem_rready,

  input  addr_t mem_awaddr,
  input  logic  mem_awvalid,
  output logic  mem_awready,
  input  beat_t mem_wdata,
  input  strb_t mem_wstrb,
  input  logic  mem_wvalid,
  output logic  mem_wready,
  output logic  mem_bvalid,
  input  logic  mem_bready
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_HAVE_ADDR,
    WR_HAVE_DATA,
    WR_RESP
  } wr_state_t;

  beat_t      mem [MEM_WORDS];

  rd_state_t  rd_state;
  beat_t      rdata_q;

  wr_state_t  wr_state;
  wr_state_t  wr_state_next;
  addr_t      awaddr_q;
  beat_t      wdata_q;
  strb_t      wstrb_q;
  addr_t      wr_addr;
  beat_t      wr_data;
  strb_t      wr_strb;
  logic       wr_en;
  logic [IDX_W-1:0] wr_idx;

  // read side
  assign mem_arready = (rd_state == RD_IDLE);
  assign mem_rvalid  = (rd_state == RD_RESP);
  assign mem_rdata   = rdata_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: if (mem_arvalid) rd_state <= RD_RESP;
        RD_RESP: if (mem_rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mem_arvalid && mem_arready) begin
      rdata_q <= mem[mem_araddr[IDX_W+2:3]];
    end
  end

  // write side, each half is taken once per write
  assign mem_awready = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_DATA);
  assign mem_wready  = (wr_state == WR_IDLE) || (wr_state == WR_HAVE_ADDR);
  assign mem_bvalid  = (wr_state == WR_RESP);

  // pick latched or incoming half
  assign wr_addr = (wr_state == WR_HAVE_ADDR) ? awaddr_q : mem_awaddr;
  assign wr_data = (wr_state == WR_HAVE_DATA) ? wdata_q : mem_wdata;
  assign wr_strb = (wr_state == WR_HAVE_DATA) ? wstrb_q : mem_wstrb;
  assign wr_idx  = wr_addr[IDX_W+2:3];

  always_comb begin
    wr_state_next = wr_state;
    wr_en         = 1'b0;
    case (wr_state)
      WR_IDLE: begin
        if (mem_awvalid && mem_wvalid) begin
          wr_en         = 1'b1;
          wr_state_next = WR_RESP;
        end else if (mem_awvalid) begin
          wr_state_next = WR_HAVE_ADDR;
        end else if (mem_wvalid) begin
          wr_state_next = WR_HAVE_DATA;
        end
      end
      WR_HAVE_ADDR: begin
        if (mem_wvalid) begin
          wr_en         = 1'b1;
          wr_state_next = WR_RESP;
        end
      end
      WR_HAVE_DATA: begin
        if (mem_awvalid) begin
          wr_en         = 1'b1;
          wr_state_next = WR_RESP;
        end
      end
      default: begin
        if (mem_bready) wr_state_next = WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_awvalid && mem_awready) begin
      awaddr_q <= mem_awaddr;
    end
    if (mem_wvalid && mem_wready) begin
      wdata_q <= mem_wdata;
      wstrb_q <= mem_wstrb;
    end
  end

  // byte-masked update of the addressed beat
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < 8; i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic        clk,
  input  logic        rstn,

  input  addr_t       raddr,
  input  load_func_t  rfunc,
  input  logic        rreq_valid,
  output logic        rreq_ready,
  output word_t       rdata,
  output logic        rres_valid,
  input  logic        rres_ready,

  input  addr_t       waddr,
  input  store_func_t wfunc,
  input  word_t       wdata,
  input  logic        wreq_valid,
  output logic        wreq_ready,
  output logic        wres_valid,
  input  logic        wres_ready
);

  // lsu to memory
  addr_t mem_araddr;
  logic  mem_arvalid;
  logic  mem_arready;
  beat_t mem_rdata;
  logic  mem_rvalid;
  logic  mem_rready;
  addr_t mem_awaddr;
  logic  mem_awvalid;
  logic  mem_awready;
  beat_t mem_wdata;
  strb_t mem_wstrb;
  logic  mem_wvalid;
  logic  mem_wready;
  logic  mem_bvalid;
  logic  mem_bready;

  lsu u_lsu (
    .clk         (clk),
    .rstn        (rstn),
    .raddr       (raddr),
    .rfunc       (rfunc),
    .rreq_valid  (rreq_valid),
    .rreq_ready  (rreq_ready),
    .rdata       (rdata),
    .rres_valid  (rres_valid),
    .rres_ready  (rres_ready),
    .waddr       (waddr),
    .wfunc       (wfunc),
    .wdata       (wdata),
    .wreq_valid  (wreq_valid),
    .wreq_ready  (wreq_ready),
    .wres_valid  (wres_valid),
    .wres_ready  (wres_ready),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_rdata   (mem_rdata),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .mem_awaddr  (mem_awaddr),
    .mem_awvalid (mem_awvalid),
    .mem_awready (mem_awready),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_wvalid  (mem_wvalid),
    .mem_wready  (mem_wready),
    .mem_bvalid  (mem_bvalid),
    .mem_bready  (mem_bready)
  );

  axi_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk         (clk),
    .rstn        (rstn),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_rdata   (mem_rdata),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready),
    .mem_awaddr  (mem_awaddr),
    .mem_awvalid (mem_awvalid),
    .mem_awready (mem_awready),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_wvalid  (mem_wvalid),
    .mem_wready  (mem_wready),
    .mem_bvalid  (mem_bvalid),
    .mem_bready  (mem_bready)
  );

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int MAX_LINES = 128;

  logic        clk;
  logic        rstn;
  addr_t       raddr;
  load_func_t  rfunc;
  logic        rreq_valid;
  logic        rreq_ready;
  word_t       rdata;
  logic        rres_valid;
  logic        rres_ready;
  addr_t       waddr;
  store_func_t wfunc;
  word_t       wdata;
  logic        wreq_valid;
  logic        wreq_ready;
  logic        wres_valid;
  logic        wres_ready;

  // each test line holds kind, func, addr and data
  word_t  tests [0:4*MAX_LINES-1];
  int     num_lines = 0;
  int     value_errors = 0;
  int     protocol_errors = 0;
  int     loads_issued = 0;
  int     stores_issued = 0;
  int     rres_seen = 0;
  int     wres_seen = 0;
  integer seed = 98;
  integer stall;
  int     i;

  lsu_top #(.MEM_WORDS(256)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("FAILED %0t: %s is %b expected %b", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_resp(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("FAILED %0t: %s count %0d expected %0d", $time, what, got, exp);
      value_errors++;
    end
  endtask

  task automatic do_load(input load_func_t f, input addr_t a, input word_t exp);
    word_t held;
    logic  holding;
    rfunc      = f;
    raddr      = a;
    rreq_valid = 1'b1;
    @(negedge clk);
    while (!rreq_ready) @(negedge clk);
    @(posedge clk);
    #1 rreq_valid = 1'b0;
    loads_issued++;
    holding = 1'b0;
    @(negedge clk);
    if (!rres_valid) begin
      $display("load at %h: response did not follow one cycle after the request", a);
      protocol_errors++;
    end
    while (!(rres_valid && rres_ready)) begin
      // data must not move while the core stalls the response
      if (holding) check_word(rdata, held, $sformatf("held rdata for %h", a));
      holding = rres_valid;
      held    = rdata;
      @(negedge clk);
    end
    check_word(rdata, exp, $sformatf("load func %0d addr %h", f, a));
    @(posedge clk);
    #1;
  endtask

  task automatic do_store(input store_func_t f, input addr_t a, input word_t d);
    wfunc      = f;
    waddr      = a;
    wdata      = d;
    wreq_valid = 1'b1;
    @(negedge clk);
    while (!wreq_ready) @(negedge clk);
    @(posedge clk);
    #1 wreq_valid = 1'b0;
    stores_issued++;
    @(negedge clk);
    if (!wres_valid) begin
      $display("store at %h: response did not follow one cycle after the request", a);
      protocol_errors++;
    end
    while (!(wres_valid && wres_ready)) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // random stalls on both response channels
  initial begin
    forever begin
      @(posedge clk);
      #1;
      stall      = $random(seed);
      rres_ready = stall[0];
      stall      = $random(seed);
      wres_ready = stall[0];
    end
  end

  // every response transfer is counted here
  always @(negedge clk) begin
    if (rstn && rres_valid && rres_ready) rres_seen++;
    if (rstn && wres_valid && wres_ready) wres_seen++;
  end

  initial begin
    @(posedge rstn);
    repeat (40 * num_lines + 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped responding",
             40 * num_lines + 20);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    rstn       = 1'b0;
    raddr      = '0;
    rfunc      = LD_W;
    rreq_valid = 1'b0;
    rres_ready = 1'b0;
    waddr      = '0;
    wfunc      = ST_W;
    wdata      = '0;
    wreq_valid = 1'b0;
    wres_ready = 1'b0;
    $readmemh("dv/lsu_tests.txt", tests);
    while (num_lines < MAX_LINES && tests[4*num_lines] !== 'x) num_lines++;
    if (num_lines == 0) begin
      $display("no test lines could be read from dv/lsu_tests.txt");
      protocol_errors++;
    end
    repeat (8) @(posedge clk);
    #1 rstn = 1'b1;
    @(negedge clk);
    check_flag(rres_valid, 1'b0, "rres_valid after reset");
    check_flag(wres_valid, 1'b0, "wres_valid after reset");
    check_flag(rreq_ready, 1'b1, "rreq_ready after reset");
    check_flag(wreq_ready, 1'b1, "wreq_ready after reset");
    @(posedge clk);
    #1;
    i = 0;
    while (i < num_lines) begin
      case (tests[4*i])
        0: do_store(store_func_t'(tests[4*i+1][2:0]), tests[4*i+2], tests[4*i+3]);
        1: do_load(load_func_t'(tests[4*i+1][2:0]), tests[4*i+2], tests[4*i+3]);
        2: begin
          // store line and the load line after it go out together
          if (i + 1 >= num_lines || tests[4*i+4] != 1) begin
            $display("paired store on line %0d has no load line after it", i);
            protocol_errors++;
          end else begin
            fork
              do_store(store_func_t'(tests[4*i+1][2:0]), tests[4*i+2], tests[4*i+3]);
              do_load(load_func_t'(tests[4*i+5][2:0]), tests[4*i+6], tests[4*i+7]);
            join
          end
          i++;
        end
        default: begin
          $display("test line %0d has an unknown kind %0d", i, tests[4*i]);
          protocol_errors++;
        end
      endcase
      i++;
    end
    repeat (2) @(posedge clk);
    check_resp(rres_seen, loads_issued, "load responses");
    check_resp(wres_seen, stores_issued, "store responses");
    $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dv/lsu_tests.txt */
// kind (0 store, 1 load, 2 store paired with the next load line), func, addr, data
// data is the store data, or the expected 32-bit load result
0 2 00000000 11223344
0 2 00000004 55667788
1 2 00000000 11223344
1 2 00000004 55667788
0 2 00000008 13121110
0 2 0000000c 17161514
0 0 00000009 123456ee
0 0 0000000a ffffff80
0 0 0000000d 0000007f
0 0 0000000e abcdef01
1 2 00000008 1380ee10
1 2 0000000c 17017f14
0 2 00000010 23222120
0 2 00000014 27262524
0 0 00000010 00000091
0 0 00000013 00000045
0 0 00000014 000000c3
0 0 00000017 0000003c
1 2 00000010 45222191
1 2 00000014 3c2625c3
0 2 00000018 33323130
0 2 0000001c 37363534
0 1 00000018 00008001
0 1 0000001a 55557ffe
0 1 0000001c 0000c0de
0 1 0000001e ffff1234
1 2 00000018 7ffe8001
1 2 0000001c 1234c0de
1 0 0000000a ffffff80
1 4 0000000a 00000080
1 0 0000000d 0000007f
1 4 00000009 000000ee
1 0 00000014 ffffffc3
1 0 00000017 0000003c
1 1 00000018 ffff8001
1 5 00000018 00008001
1 1 0000001a 00007ffe
1 5 0000001c 0000c0de
1 1 0000001e 00001234
0 2 00000020 cafef00d
0 2 00000024 00000000
2 2 00000024 0badf00d
1 2 00000000 11223344
2 0 00000020 aabbcc99
1 2 0000000c 17017f14
1 2 00000024 0badf00d
1 2 00000020 cafef099

/* files.f */
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/axi_sram.sv
hdl/lsu_top.sv
dv/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu.sv
      - hdl/axi_sram.sv
      - hdl/lsu_top.sv
  - target: simulation
    files:
      - dv/lsu_tb.sv
